// File: files.f
hdl/polar_pkg.sv
hdl/decode_ctrl.sv
hdl/llr_buffer.sv
hdl/sc_pe_array.sv
hdl/partial_sum.sv
hdl/result_packer.sv
hdl/polar_decoder_top.sv
testbench/polar_decoder_props.sv
testbench/tb_polar_decoder.sv

// File: Bender.yml
package:
  name: polar_decoder

sources:
  - hdl/polar_pkg.sv
  - hdl/decode_ctrl.sv
  - hdl/llr_buffer.sv
  - hdl/sc_pe_array.sv
  - hdl/partial_sum.sv
  - hdl/result_packer.sv
  - hdl/polar_decoder_top.sv
  - target: test
    files:
      - testbench/polar_decoder_props.sv
      - testbench/tb_polar_decoder.sv

// File: testbench/tb_polar_decoder.sv
`timescale 1ns/10ps

module tb_polar_decoder;
    import polar_pkg::*;

    localparam int NUM_RUNS = 5;
    localparam int MAX_PKTS = 6;

    logic                clk;
    logic                rst_n;
    logic                module_en;
    logic [RADDR_W-1:0]  raddr;
    rd_word_u            rdata;
    logic [WADDR_W-1:0]  waddr;
    logic [CODE_LEN-1:0] wdata;
    logic                proc_done;

    rd_word_u            rom      [1 << RADDR_W];
    logic [CODE_LEN-1:0] wmem     [1 << WADDR_W];
    logic [CODE_LEN-1:0] exp_word [MAX_PKTS];
    int                  run_pkts [NUM_RUNS];
    int                  cycles      = 0;
    int                  cycle_limit = 0;
    int                  done_cnt    = 0;

    // reference model state with one row per tree level
    int                  node_llr [CODE_LOG2+1][CODE_LEN];
    logic                node_x   [CODE_LOG2+1][CODE_LEN];
    logic [CODE_LEN-1:0] ref_u;
    logic [CODE_LEN-1:0] ref_frozen;

    polar_decoder_top dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .module_en_i (module_en),
        .raddr_o     (raddr),
        .rdata_i     (rdata),
        .waddr_o     (waddr),
        .wdata_o     (wdata),
        .proc_done_o (proc_done)
    );

    // read memory answers in the same cycle
    assign rdata = rom[raddr];

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // output memory stores every cycle without an enable
    always @(posedge clk) begin
        wmem[waddr] <= wdata;
    end

    always @(negedge clk) begin
        if (proc_done) begin
            done_cnt++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: proc_done never came within %0d cycles", cycle_limit);
            $display(">>> FAIL");
            $fatal(1, "simulation timeout");
        end
    end

    task automatic check(input string what, input logic [CODE_LEN-1:0] got,
                         input logic [CODE_LEN-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, exp);
            $display(">>> FAIL");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    // ======================================================================
    // SC reference model
    // ======================================================================

    function automatic int f_min(int a, int b);
        int ma;
        int mb;
        int m;
        ma = (a < 0) ? -a : a;
        mb = (b < 0) ? -b : b;
        m  = (ma < mb) ? ma : mb;
        return ((a < 0) != (b < 0)) ? -m : m;
    endfunction

    // node at tree level lvl whose first decoded bit is at index first
    function automatic void sc_node(int lvl, int first);
        int h;
        h = (CODE_LEN >> lvl) / 2;
        if (lvl == CODE_LOG2) begin
            ref_u[first]   = ref_frozen[first] ? 1'b0 : (node_llr[lvl][0] < 0);
            node_x[lvl][0] = ref_u[first];
        end else begin
            for (int i = 0; i < h; i++) begin
                node_llr[lvl+1][i] = f_min(node_llr[lvl][i], node_llr[lvl][i+h]);
            end
            sc_node(lvl + 1, first);
            // left partial sums kept in this level while the right child runs
            for (int i = 0; i < h; i++) begin
                node_x[lvl][i]     = node_x[lvl+1][i];
                node_llr[lvl+1][i] = node_x[lvl][i] ? node_llr[lvl][i+h] - node_llr[lvl][i]
                                                    : node_llr[lvl][i+h] + node_llr[lvl][i];
            end
            sc_node(lvl + 1, first + h);
            for (int i = 0; i < h; i++) begin
                node_x[lvl][i]   = node_x[lvl][i] ^ node_x[lvl+1][i];
                node_x[lvl][i+h] = node_x[lvl+1][i];
            end
        end
    endfunction

    // ======================================================================
    // stimulus
    // ======================================================================

    task automatic build_packet(input int p, input logic [CODE_LEN-1:0] mask);
        int v;
        int base;
        int pos;
        base = 1 + p * (1 + LLR_WORDS);
        rom[base]                  = '0;
        rom[base].info.frozen_mask = mask;
        for (int i = 0; i < CODE_LEN; i++) begin
            v = int'($urandom_range(4095)) - 2048;
            rom[base + 1 + i / LLR_PER_WORD].llr[i % LLR_PER_WORD] = llr_t'(v);
            node_llr[0][i] = v;
        end
        ref_frozen = mask;
        sc_node(0, 0);
        // info bits lsb first
        exp_word[p] = '0;
        pos = 0;
        for (int i = 0; i < CODE_LEN; i++) begin
            if (!mask[i]) begin
                exp_word[p][pos] = ref_u[i];
                pos++;
            end
        end
    endtask

    task automatic do_run(input int pkts, input bit extremes);
        logic [CODE_LEN-1:0] mask;
        @(negedge clk);
        rom[0]             = '0;
        rom[0].hdr.pkt_cnt = PKT_W'(pkts);
        for (int p = 0; p < pkts; p++) begin
            if (extremes) begin
                mask = p[0] ? {CODE_LEN{1'b0}} : {CODE_LEN{1'b1}};
            end else begin
                mask = {$urandom, $urandom};
            end
            build_packet(p, mask);
        end
        for (int a = 0; a < (1 << WADDR_W); a++) begin
            wmem[a] = 'x;
        end
        @(posedge clk);
        done_cnt = 0;
        module_en <= 1'b1;
        @(posedge clk);
        module_en <= 1'b0;
        while (done_cnt == 0) begin
            @(negedge clk);
        end
        // room for a second done pulse to show up
        repeat (4) @(negedge clk);
        check("proc_done pulse count", done_cnt, 1);
        for (int p = 0; p < pkts; p++) begin
            check($sformatf("word %0d of %0d", p, pkts), wmem[p], exp_word[p]);
        end
    endtask

    initial begin
        int total;
        rst_n     <= 1'b0;
        module_en <= 1'b0;
        void'($urandom(14538));
        run_pkts[0] = 1;
        run_pkts[1] = 2 + $urandom_range(4);
        run_pkts[2] = 2;
        run_pkts[3] = 2 + $urandom_range(4);
        run_pkts[4] = 2 + $urandom_range(4);
        total = 0;
        foreach (run_pkts[r]) begin
            total += 4 + 389 * run_pkts[r];
        end
        cycle_limit = total * 3 / 2;
        for (int a = 0; a < (1 << RADDR_W); a++) begin
            rom[a] = {LLR_PER_WORD{1'b0, 11'(a)}};
        end
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check("proc_done after reset", proc_done, '0);
        check("waddr after reset", waddr, '0);
        check("wdata after reset", wdata, '0);
        check("raddr after reset", raddr, '0);
        repeat (3) @(posedge clk);
        // single packet and then a longer run
        do_run(run_pkts[0], 1'b0);
        do_run(run_pkts[1], 1'b0);
        // all frozen and all clear masks
        do_run(run_pkts[2], 1'b1);
        // back to back with fresh contents
        do_run(run_pkts[3], 1'b0);
        do_run(run_pkts[4], 1'b0);
        check("bound assertion failures", dut.u_props.fail_cnt, '0);
        $display(">>> PASS");
        $finish;
    end

endmodule

// File: testbench/polar_decoder_props.sv
`timescale 1ns/10ps

module polar_decoder_props (
    input logic                          clk,
    input logic                          rst_n,
    input logic [2:0]                    state_i,
    input logic [polar_pkg::PKT_W-1:0]   pkt_cnt_i,
    input logic [polar_pkg::RADDR_W-1:0] raddr_i,
    input logic [polar_pkg::WADDR_W-1:0] waddr_i,
    input logic                          proc_done_i
);

    int unsigned fail_cnt = 0;

    done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        proc_done_i |=> !proc_done_i)
        else begin
            $error("proc_done held high for more than one cycle");
            fail_cnt++;
        end

    // IDLE is encoded as zero
    raddr_idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (state_i == 3'd0) |-> (raddr_i == '0))
        else begin
            $error("read address not zero while idle");
            fail_cnt++;
        end

    waddr_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        (pkt_cnt_i != '0) |-> (7'(waddr_i) < pkt_cnt_i))
        else begin
            $error("write address reached the packet count");
            fail_cnt++;
        end

endmodule

bind polar_decoder_top polar_decoder_props u_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .state_i     (u_ctrl.state_q),
    .pkt_cnt_i   (u_ctrl.pkt_cnt_q),
    .raddr_i     (raddr_o),
    .waddr_i     (waddr_o),
    .proc_done_i (proc_done_o)
);

// File: hdl/polar_decoder_top.sv
`timescale 1ns/10ps

module polar_decoder_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              module_en_i,
    output logic [polar_pkg::RADDR_W-1:0]     raddr_o,
    input  polar_pkg::rd_word_u               rdata_i,
    output logic [polar_pkg::WADDR_W-1:0]     waddr_o,
    output logic [polar_pkg::CODE_LEN-1:0]    wdata_o,
    output logic                              proc_done_o
);
    import polar_pkg::*;

    sched_t              sched;
    logic                llr_load;
    logic                info_load;
    logic [1:0]          word_idx;
    logic [PKT_W-1:0]    pkt;
    llr_vec_t            llr_vec;
    logic [NUM_PE-1:0]   psum;
    logic                leaf_sign;
    decision_t           decision;

    decode_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .module_en_i (module_en_i),
        .rdata_i     (rdata_i),
        .raddr_o     (raddr_o),
        .sched_o     (sched),
        .llr_load_o  (llr_load),
        .word_idx_o  (word_idx),
        .info_load_o (info_load),
        .pkt_o       (pkt),
        .proc_done_o (proc_done_o)
    );

    llr_buffer u_llr (
        .clk        (clk),
        .rst_n      (rst_n),
        .llr_load_i (llr_load),
        .word_idx_i (word_idx),
        .rdata_i    (rdata_i),
        .llr_o      (llr_vec)
    );

    sc_pe_array u_pe (
        .clk         (clk),
        .rst_n       (rst_n),
        .sched_i     (sched),
        .llr_i       (llr_vec),
        .psum_i      (psum),
        .leaf_sign_o (leaf_sign)
    );

    partial_sum u_psum (
        .clk         (clk),
        .rst_n       (rst_n),
        .sched_i     (sched),
        .info_load_i (info_load),
        .rdata_i     (rdata_i),
        .leaf_sign_i (leaf_sign),
        .psum_o      (psum),
        .decision_o  (decision)
    );

    result_packer u_pack (
        .clk        (clk),
        .rst_n      (rst_n),
        .sched_i    (sched),
        .pkt_i      (pkt),
        .decision_i (decision),
        .waddr_o    (waddr_o),
        .wdata_o    (wdata_o)
    );

endmodule

// File: hdl/result_packer.sv
`timescale 1ns/10ps

module result_packer (
    input  logic                           clk,
    input  logic                           rst_n,
    input  polar_pkg::sched_t              sched_i,
    input  logic [polar_pkg::PKT_W-1:0]    pkt_i,
    input  polar_pkg::decision_t           decision_i,
    output logic [polar_pkg::WADDR_W-1:0]  waddr_o,
    output logic [polar_pkg::CODE_LEN-1:0] wdata_o
);
    import polar_pkg::*;

    // next free position in the output word
    logic [CODE_LOG2-1:0] pos_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            waddr_o <= '0;
            wdata_o <= '0;
            pos_q   <= '0;
        end else begin
            // write address trails the packet number by one cycle
            waddr_o <= pkt_i[WADDR_W-1:0];
            if (sched_i.pkt_start) begin
                wdata_o <= '0;
                pos_q   <= '0;
            end else if (decision_i.valid && !decision_i.frozen) begin
                // info bits only, lsb first
                wdata_o[pos_q] <= decision_i.hard;
                pos_q          <= pos_q + 1'b1;
            end
        end
    end

endmodule

// File: hdl/partial_sum.sv
`timescale 1ns/10ps

module partial_sum (
    input  logic                         clk,
    input  logic                         rst_n,
    input  polar_pkg::sched_t            sched_i,
    input  logic                         info_load_i,
    input  polar_pkg::rd_word_u          rdata_i,
    input  logic                         leaf_sign_i,
    output logic [polar_pkg::NUM_PE-1:0] psum_o,
    output polar_pkg::decision_t         decision_o
);
    import polar_pkg::*;

    logic [CODE_LEN-1:0] u_q;
    logic [CODE_LEN-1:0] mask_q;
    logic [CODE_LEN-1:0] lvl [CODE_LOG2];
    logic                frozen;
    logic                hard;

    // ====================================================================
    // xor butterfly over the decided bits
    // ====================================================================

    // level k encodes aligned blocks of 2**k bits
    always_comb begin
        lvl[0] = u_q;
        for (int k = 1; k < CODE_LOG2; k++) begin
            for (int i = 0; i < CODE_LEN; i++) begin
                if (i[k-1]) begin
                    lvl[k][i] = lvl[k-1][i];
                end else begin
                    lvl[k][i] = lvl[k-1][i] ^ lvl[k-1][i + (1 << (k - 1))];
                end
            end
        end
    end

    // left half of the current subtree, based at the upper bits of the index
    always_comb begin
        logic [CODE_LEN-1:0]  lvl_sel;
        logic [CODE_LOG2-1:0] base;
        logic [CODE_LOG2-1:0] idx;
        lvl_sel = lvl[CODE_LOG2 - 1 - int'(sched_i.stage)];
        base    = sched_i.bit_idx & ~CODE_LOG2'((CODE_LEN >> sched_i.stage) - 1);
        psum_o  = '0;
        for (int i = 0; i < NUM_PE; i++) begin
            idx = base | CODE_LOG2'(i);
            if (i < (NUM_PE >> sched_i.stage)) begin
                psum_o[i] = lvl_sel[idx];
            end
        end
    end

    // ====================================================================
    // hard decision
    // ====================================================================

    assign frozen = mask_q[sched_i.bit_idx];
    assign hard   = frozen ? 1'b0 : leaf_sign_i;

    always_comb begin
        decision_o.valid  = sched_i.leaf;
        decision_o.frozen = frozen;
        decision_o.hard   = hard;
    end

    always_ff @(posedge clk) begin
        if (info_load_i) begin
            mask_q <= rdata_i.info.frozen_mask;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            u_q <= '0;
        end else if (sched_i.leaf) begin
            u_q[sched_i.bit_idx] <= hard;
        end
    end

endmodule

// File: hdl/sc_pe_array.sv
`timescale 1ns/10ps

module sc_pe_array (
    input  logic                         clk,
    input  logic                         rst_n,
    input  polar_pkg::sched_t            sched_i,
    input  polar_pkg::llr_vec_t          llr_i,
    input  logic [polar_pkg::NUM_PE-1:0] psum_i,
    output logic                         leaf_sign_o
);
    import polar_pkg::*;

    pe_t op_a [NUM_PE];
    pe_t op_b [NUM_PE];
    pe_t f_d  [NUM_PE];
    pe_t g_d  [NUM_PE];
    pe_t f_q  [NUM_PE];
    pe_t g_q  [NUM_PE];

    // min-sum f: sign product times smaller magnitude
    function automatic pe_t f_op(pe_t a, pe_t b);
        pe_t a_mag;
        pe_t b_mag;
        pe_t m;
        a_mag = a[PE_W-1] ? -a : a;
        b_mag = b[PE_W-1] ? -b : b;
        m     = (a_mag < b_mag) ? a_mag : b_mag;
        return (a[PE_W-1] ^ b[PE_W-1]) ? -m : m;
    endfunction

    // ====================================================================
    // operand selection
    // ====================================================================

    always_comb begin
        int   half;
        logic sel_g;
        half  = NUM_PE >> sched_i.stage;
        // upper bit of the bit index picks the f or g branch of the tree
        sel_g = (sched_i.stage == 3'd0) ? 1'b0
                                        : sched_i.bit_idx[CODE_LOG2 - int'(sched_i.stage)];
        for (int i = 0; i < NUM_PE; i++) begin
            op_a[i] = '0;
            op_b[i] = '0;
            if (sched_i.stage == 3'd0) begin
                op_a[i] = llr_i[i];
                op_b[i] = llr_i[i + NUM_PE];
            end else if (i < half) begin
                op_a[i] = sel_g ? g_q[i] : f_q[i];
                op_b[i] = sel_g ? g_q[i + half] : f_q[i + half];
            end
        end
    end

    // ====================================================================
    // f and g nodes
    // ====================================================================

    always_comb begin
        for (int i = 0; i < NUM_PE; i++) begin
            f_d[i] = f_op(op_a[i], op_b[i]);
            g_d[i] = psum_i[i] ? op_b[i] - op_a[i] : op_b[i] + op_a[i];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            f_q <= '{default: '0};
            g_q <= '{default: '0};
        end else if (sched_i.decode) begin
            f_q <= f_d;
            g_q <= g_d;
        end
    end

    // leaf llr of node 0, even bits are f and odd bits g
    assign leaf_sign_o = sched_i.bit_idx[0] ? g_d[0][PE_W-1] : f_d[0][PE_W-1];

endmodule

// File: hdl/llr_buffer.sv
`timescale 1ns/10ps

module llr_buffer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                llr_load_i,
    input  logic [1:0]          word_idx_i,
    input  polar_pkg::rd_word_u rdata_i,
    output polar_pkg::llr_vec_t llr_o
);
    import polar_pkg::*;

    llr_vec_t llr_q;

    // word k fills channel llrs 16k .. 16k+15
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            llr_q <= '0;
        end else if (llr_load_i) begin
            for (int k = 0; k < LLR_PER_WORD; k++) begin
                llr_q[int'(word_idx_i) * LLR_PER_WORD + k] <= rdata_i.llr[k];
            end
        end
    end

    assign llr_o = llr_q;

endmodule

// File: hdl/decode_ctrl.sv
`timescale 1ns/10ps

module decode_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          module_en_i,
    input  polar_pkg::rd_word_u           rdata_i,
    output logic [polar_pkg::RADDR_W-1:0] raddr_o,
    output polar_pkg::sched_t             sched_o,
    output logic                          llr_load_o,
    output logic [1:0]                    word_idx_o,
    output logic                          info_load_o,
    output logic [polar_pkg::PKT_W-1:0]   pkt_o,
    output logic                          proc_done_o
);
    import polar_pkg::*;

    typedef enum logic [2:0] {
        IDLE, HEADER, INFO, LLR, DECODE, FINISH
    } state_e;

    state_e               state_q;
    state_e               state_d;
    logic [1:0]           cnt_q;
    logic [CODE_LOG2-1:0] bit_q;
    logic [2:0]           stage_q;
    logic [PKT_W-1:0]     pkt_cnt_q;
    logic [PKT_W-1:0]     cur_pkt_q;
    logic [RADDR_W-1:0]   raddr_q;
    logic                 done_q;
    logic                 bit_end;
    logic                 pkt_end;
    logic                 last_pkt;

    assign bit_end  = (stage_q == 3'(CODE_LOG2 - 1));
    assign pkt_end  = bit_end && (bit_q == CODE_LOG2'(CODE_LEN - 1));
    assign last_pkt = (cur_pkt_q == pkt_cnt_q - 1'b1);

    // ====================================================================
    // packet FSM
    // ====================================================================

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (module_en_i) state_d = HEADER;
            HEADER:  state_d = (rdata_i.hdr.pkt_cnt == '0) ? FINISH : INFO;
            INFO:    state_d = LLR;
            LLR:     if (cnt_q == 2'(LLR_WORDS - 1)) state_d = DECODE;
            DECODE:  if (pkt_end) state_d = last_pkt ? FINISH : INFO;
            FINISH:  if (cnt_q == 2'd1) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= IDLE;
            cnt_q     <= '0;
            pkt_cnt_q <= '0;
            cur_pkt_q <= '0;
            done_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            // word counter for llr loading and the finish delay
            cnt_q   <= (state_q == LLR || state_q == FINISH) ? cnt_q + 2'd1 : '0;
            if (state_q == HEADER) begin
                pkt_cnt_q <= rdata_i.hdr.pkt_cnt;
            end
            // last packet number is kept so the write port stays on it
            if (state_q == IDLE && module_en_i) begin
                cur_pkt_q <= '0;
            end else if (state_q == DECODE && pkt_end && !last_pkt) begin
                cur_pkt_q <= cur_pkt_q + 1'b1;
            end
            done_q <= (state_q == FINISH) && (cnt_q == 2'd0);
        end
    end

    // ====================================================================
    // bit and stage counters, read address
    // ====================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_q   <= '0;
            stage_q <= '0;
        end else if (state_q == DECODE) begin
            stage_q <= bit_end ? 3'd0 : stage_q + 3'd1;
            if (bit_end) begin
                bit_q <= bit_q + 1'b1;
            end
        end else begin
            bit_q   <= '0;
            stage_q <= '0;
        end
    end

    // one word per cycle through header, info and llr words
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            raddr_q <= '0;
        end else begin
            case (state_q)
                HEADER, INFO, LLR: raddr_q <= raddr_q + 1'b1;
                FINISH:            raddr_q <= '0;
                default:           raddr_q <= raddr_q;
            endcase
        end
    end

    always_comb begin
        sched_o.bit_idx   = bit_q;
        sched_o.stage     = stage_q;
        sched_o.decode    = (state_q == DECODE);
        sched_o.leaf      = (state_q == DECODE) && bit_end;
        sched_o.pkt_start = (state_q == INFO);
    end

    assign raddr_o     = raddr_q;
    assign llr_load_o  = (state_q == LLR);
    assign word_idx_o  = cnt_q;
    assign info_load_o = (state_q == INFO);
    assign pkt_o       = cur_pkt_q;
    assign proc_done_o = done_q;

endmodule

// File: hdl/polar_pkg.sv
package polar_pkg;

    // ====================================================================
    // sizes
    // ====================================================================

    localparam int CODE_LEN     = 64;
    localparam int CODE_LOG2    = 6;
    localparam int LLR_W        = 12;
    localparam int PE_W         = 22;
    localparam int NUM_PE       = CODE_LEN / 2;
    localparam int LLR_PER_WORD = 16;
    localparam int LLR_WORDS    = CODE_LEN / LLR_PER_WORD;
    localparam int RD_W         = LLR_PER_WORD * LLR_W;
    localparam int RADDR_W      = 11;
    localparam int WADDR_W      = 6;
    localparam int PKT_W        = 7;

    // value types, signed so element selects keep their sign
    typedef logic signed [LLR_W-1:0] llr_t;
    typedef logic signed [PE_W-1:0]  pe_t;
    typedef llr_t [CODE_LEN-1:0]     llr_vec_t;
    typedef llr_t [LLR_PER_WORD-1:0] llr_word_t;

    // ====================================================================
    // read word, decoded as header, info or llr word
    // ====================================================================

    typedef struct packed {
        logic [RD_W-PKT_W-1:0] rsvd;
        logic [PKT_W-1:0]      pkt_cnt;
    } hdr_view_t;

    typedef struct packed {
        logic [RD_W-CODE_LEN-1:0] rsvd;
        logic [CODE_LEN-1:0]      frozen_mask;
    } info_view_t;

    // llr field 0 in the lowest bits
    typedef union packed {
        hdr_view_t  hdr;
        info_view_t info;
        llr_word_t  llr;
    } rd_word_u;

    // broadcast schedule from the controller
    typedef struct packed {
        logic [CODE_LOG2-1:0] bit_idx;
        logic [2:0]           stage;
        logic                 decode;
        logic                 leaf;
        logic                 pkt_start;
    } sched_t;

    typedef struct packed {
        logic valid;
        logic frozen;
        logic hard;
    } decision_t;

endpackage
